// ==== Makefile ====
TOP := tb_jpeg_idct_ram
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

lint:
	verilator --lint-only -Wall -f filelist.f --top-module jpeg_idct_ram

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
hdl/jpeg_idct_pkg.sv
hdl/jpeg_coef_bank.sv
hdl/jpeg_block_tracker.sv
hdl/jpeg_read_sequencer.sv
hdl/jpeg_idct_ram.sv
testbench/tb_jpeg_idct_ram.sv

// ==== hdl/jpeg_block_tracker.sv ====
`timescale 1ns/1ps

module jpeg_block_tracker
(
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    flush_i,            // Start of image
    input  logic                    valid_i,            // Input strobe
    input  logic                    eob_i,              // Last coefficient of a block
    input  logic                    block_done_i,       // Read side finished a slot
    output logic                    ready_o,            // Write slot has room
    output logic                    wr_accept_o,        // Beat taken this cycle
    output jpeg_idct_pkg::blk_ptr_t wr_slot_o,          // Slot being filled
    output jpeg_idct_pkg::blk_ptr_t rd_slot_o,          // Slot being drained
    output logic                    rd_slot_full_o      // Drain slot holds a whole block
);

    import jpeg_idct_pkg::*;

    logic [NUM_BLOCKS-1:0] full_q;                      // One flag per ring slot
    blk_ptr_t              wr_ptr_q;
    blk_ptr_t              rd_ptr_q;
    logic                  eob_accept;

    assign ready_o        = ~full_q[wr_ptr_q];          // Stall when ring wrapped onto a full slot
    assign wr_accept_o    = valid_i && ready_o;
    assign eob_accept     = wr_accept_o && eob_i;       // EOB only counts on an accepted beat
    assign wr_slot_o      = wr_ptr_q;
    assign rd_slot_o      = rd_ptr_q;
    assign rd_slot_full_o = full_q[rd_ptr_q];

    // ----------------------------------------------------------------------
    // Ring pointers and full flags
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i || flush_i)
        begin
            full_q   <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end
        else
        begin
            // Write and read slots never coincide here since one is full and one is not
            if (eob_accept)
            begin
                full_q[wr_ptr_q] <= 1'b1;               // Block complete
                wr_ptr_q         <= wr_ptr_q + 2'd1;
            end
            if (block_done_i)
            begin
                full_q[rd_ptr_q] <= 1'b0;               // Slot free again
                rd_ptr_q         <= rd_ptr_q + 2'd1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    // Sequencer may only finish a slot the tracker marked full
    a_done_on_full: assert property (
        @(posedge clk_i) disable iff (rst_i)
        block_done_i |-> rd_slot_full_o
    );

endmodule

// ==== hdl/jpeg_coef_bank.sv ====
`timescale 1ns/1ps

module jpeg_coef_bank
#(
    parameter jpeg_idct_pkg::bank_id_t BANK_ID = 2'd0    // Index bits 2..1 served here
)
(
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    flush_i,            // Start of image
    input  jpeg_idct_pkg::coef_wr_t wr_i,               // Write beat shared by all banks
    input  jpeg_idct_pkg::coef_rd_t rd_i,               // Read request from the sequencer
    input  logic                    block_done_i,       // Last beat of rd_i.slot consumed
    output jpeg_idct_pkg::coef_t    data_o              // Masked read word
);

    import jpeg_idct_pkg::*;

    localparam int SLOT_FLAGS = BLOCK_COEFS / NUM_BANKS;    // Words one block owns in a bank

    coef_t                 mem_q [BANK_DEPTH];              // Coefficient storage
    logic [BANK_DEPTH-1:0] written_q;                       // Set when a word was stored
    coef_t                 data_q;                          // Output register
    logic                  wr_hit;                          // This bank takes the write
    bank_addr_t            wr_addr;
    bank_addr_t            rd_addr;

    // ----------------------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------------------
    // Index bits 2..1 pick the bank, the rest picks row and parity
    assign wr_hit  = wr_i.wr && (wr_i.index[2:1] == BANK_ID);
    assign wr_addr = {wr_i.slot, wr_i.index[5:3], wr_i.index[0]};
    assign rd_addr = {rd_i.slot, rd_i.addr};

    // ----------------------------------------------------------------------
    // Storage
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (wr_hit)
        begin
            mem_q[wr_addr] <= wr_i.data;                    // Plain RAM write port
        end
    end

    // Written flags
    always_ff @(posedge clk_i)
    begin
        if (rst_i || flush_i)
        begin
            written_q <= '0;                                // Image restart empties all slots
        end
        else
        begin
            if (block_done_i)
            begin
                written_q[rd_i.slot*SLOT_FLAGS +: SLOT_FLAGS] <= '0;  // Free drained slot
            end
            if (wr_hit)
            begin
                written_q[wr_addr] <= 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Read port
    // ----------------------------------------------------------------------
    // Loads only when the sequencer advances so the output holds under stall
    always_ff @(posedge clk_i)
    begin
        if (rd_i.en)
        begin
            data_q <= written_q[rd_addr] ? mem_q[rd_addr] : '0;  // Unwritten reads as zero
        end
    end

    assign data_o = data_q;

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    // Filling slot must differ from the slot being freed
    a_wr_not_clearing: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (wr_i.wr && block_done_i) |-> (wr_i.slot != rd_i.slot)
    );

endmodule

// ==== hdl/jpeg_idct_pkg.sv ====
package jpeg_idct_pkg;

    // ----------------------------------------------------------------------
    // Sizes
    // ----------------------------------------------------------------------
    localparam int NUM_BLOCKS  = 4;      // Slots in the block ring
    localparam int NUM_BANKS   = 4;      // Banks per slot, picked by index bits 2..1
    localparam int BLOCK_COEFS = 64;     // Coefficients in one 8x8 block
    localparam int BANK_DEPTH  = 64;     // Words per bank over all slots
    localparam int LAST_BEAT   = 63;     // Final output beat of a block

    // ----------------------------------------------------------------------
    // Vector types
    // ----------------------------------------------------------------------
    typedef logic [15:0] coef_t;         // One DCT coefficient
    typedef logic [5:0]  coef_idx_t;     // Natural order index 0..63
    typedef logic [1:0]  blk_ptr_t;      // Ring slot number
    typedef logic [1:0]  bank_id_t;      // Bank number
    typedef logic [3:0]  blk_addr_t;     // {row[2:0], column parity} inside one slot
    typedef logic [5:0]  bank_addr_t;    // {slot, blk_addr_t}
    typedef logic [5:0]  beat_t;         // Output beat 0..63
    typedef logic [2:0]  lane_idx_t;     // Column of the current beat

    // ----------------------------------------------------------------------
    // Grouped signals
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic      wr;                   // Accepted input beat
        blk_ptr_t  slot;                 // Slot being filled
        coef_idx_t index;                // Natural coefficient index
        coef_t     data;                 // Coefficient value
    } coef_wr_t;                         // 25 bits

    typedef struct packed {
        logic      en;                   // Load the bank output register
        blk_ptr_t  slot;                 // Slot being drained
        blk_addr_t addr;                 // Row and parity inside the slot
    } coef_rd_t;                         // 7 bits

    // Read order FSM
    typedef enum logic [1:0] {
        IDLE   = 2'd0,                   // Wait for a full slot
        SETUP  = 2'd1,                   // First bank read in flight
        ACTIVE = 2'd2                    // Output beats valid
    } rd_state_e;

endpackage

// ==== hdl/jpeg_idct_ram.sv ====
`timescale 1ns/1ps

module jpeg_idct_ram
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      img_start_i,      // Flush pulse
    input  logic                      inport_valid_i,
    input  jpeg_idct_pkg::coef_t      inport_data_i,
    input  jpeg_idct_pkg::coef_idx_t  inport_idx_i,     // Natural order index
    input  logic                      inport_eob_i,     // Last beat of a block
    input  logic                      yumi_i,           // Output beat consumed
    output logic                      ready_o,          // Input may be strobed
    output logic                      v_o,
    output jpeg_idct_pkg::coef_t      outport_data0_o,  // Column 0 or 1
    output jpeg_idct_pkg::coef_t      outport_data1_o,  // Column 2 or 3
    output jpeg_idct_pkg::coef_t      outport_data2_o,  // Column 4 or 5
    output jpeg_idct_pkg::coef_t      outport_data3_o,  // Column 6 or 7
    output jpeg_idct_pkg::lane_idx_t  outport_idx_o
);

    import jpeg_idct_pkg::*;

    logic      wr_accept;
    blk_ptr_t  wr_slot;
    blk_ptr_t  rd_slot;
    logic      rd_slot_full;
    logic      rd_en;
    blk_addr_t rd_addr;
    logic      block_done;
    coef_wr_t  bank_wr;                                 // Same write beat to every bank
    coef_rd_t  bank_rd;                                 // Same read request to every bank

    // ----------------------------------------------------------------------
    // Bus packing
    // ----------------------------------------------------------------------
    assign bank_wr.wr    = wr_accept;
    assign bank_wr.slot  = wr_slot;
    assign bank_wr.index = inport_idx_i;
    assign bank_wr.data  = inport_data_i;

    assign bank_rd.en    = rd_en;
    assign bank_rd.slot  = rd_slot;
    assign bank_rd.addr  = rd_addr;

    // ----------------------------------------------------------------------
    // Control
    // ----------------------------------------------------------------------
    jpeg_block_tracker u_tracker (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .flush_i        (img_start_i),
        .valid_i        (inport_valid_i),
        .eob_i          (inport_eob_i),
        .block_done_i   (block_done),
        .ready_o        (ready_o),
        .wr_accept_o    (wr_accept),
        .wr_slot_o      (wr_slot),
        .rd_slot_o      (rd_slot),
        .rd_slot_full_o (rd_slot_full)
    );

    jpeg_read_sequencer u_seq (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .flush_i      (img_start_i),
        .slot_full_i  (rd_slot_full),
        .yumi_i       (yumi_i),
        .rd_en_o      (rd_en),
        .rd_addr_o    (rd_addr),
        .block_done_o (block_done),
        .v_o          (v_o),
        .idx_o        (outport_idx_o)
    );

    // ----------------------------------------------------------------------
    // Banks, one per index pair
    // ----------------------------------------------------------------------
    jpeg_coef_bank #(.BANK_ID(2'd0)) u_bank0 (
        .clk_i (clk_i), .rst_i (rst_i), .flush_i (img_start_i),
        .wr_i (bank_wr), .rd_i (bank_rd), .block_done_i (block_done),
        .data_o (outport_data0_o)
    );

    jpeg_coef_bank #(.BANK_ID(2'd1)) u_bank1 (
        .clk_i (clk_i), .rst_i (rst_i), .flush_i (img_start_i),
        .wr_i (bank_wr), .rd_i (bank_rd), .block_done_i (block_done),
        .data_o (outport_data1_o)
    );

    jpeg_coef_bank #(.BANK_ID(2'd2)) u_bank2 (
        .clk_i (clk_i), .rst_i (rst_i), .flush_i (img_start_i),
        .wr_i (bank_wr), .rd_i (bank_rd), .block_done_i (block_done),
        .data_o (outport_data2_o)
    );

    jpeg_coef_bank #(.BANK_ID(2'd3)) u_bank3 (
        .clk_i (clk_i), .rst_i (rst_i), .flush_i (img_start_i),
        .wr_i (bank_wr), .rd_i (bank_rd), .block_done_i (block_done),
        .data_o (outport_data3_o)
    );

endmodule

// ==== hdl/jpeg_read_sequencer.sv ====
`timescale 1ns/1ps

module jpeg_read_sequencer
(
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     flush_i,           // Start of image
    input  logic                     slot_full_i,       // Drain slot holds a whole block
    input  logic                     yumi_i,            // Consumer takes the beat
    output logic                     rd_en_o,           // Bank output registers load
    output jpeg_idct_pkg::blk_addr_t rd_addr_o,         // Row and parity to read
    output logic                     block_done_o,      // Beat 63 consumed
    output logic                     v_o,               // Output beat valid
    output jpeg_idct_pkg::lane_idx_t idx_o              // Column of the current beat
);

    import jpeg_idct_pkg::*;

    rd_state_e state_q;
    rd_state_e state_next;
    beat_t     beat_q;                                  // Beat currently on the outputs
    blk_addr_t addr_q;                                  // Address for the next beat
    logic      beat_take;                               // Beat consumed this cycle

    assign v_o          = (state_q == ACTIVE);
    assign beat_take    = v_o && yumi_i;
    assign block_done_o = beat_take && (beat_q == beat_t'(LAST_BEAT));
    assign rd_en_o      = (state_q == SETUP) || beat_take;  // Read only when advancing
    assign rd_addr_o    = addr_q;
    assign idx_o        = beat_q[2:0];

    // ----------------------------------------------------------------------
    // State machine
    // ----------------------------------------------------------------------
    always_comb
    begin
        state_next = state_q;
        case (state_q)
            IDLE:
            begin
                if (slot_full_i)
                begin
                    state_next = SETUP;                 // Block ready in drain slot
                end
            end
            SETUP:
            begin
                state_next = ACTIVE;                    // Beat 0 word lands this edge
            end
            ACTIVE:
            begin
                if (block_done_o)
                begin
                    state_next = IDLE;
                end
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i || flush_i)
        begin
            state_q <= IDLE;
        end
        else
        begin
            state_q <= state_next;
        end
    end

    // ----------------------------------------------------------------------
    // Beat counter and address pattern
    // ----------------------------------------------------------------------
    // Parity runs 0,1,0,1,1,0,1,0 per row so each step depends on beat bits 2..0
    always_ff @(posedge clk_i)
    begin
        if (rst_i || flush_i || (state_q == IDLE))
        begin
            beat_q <= '0;
            addr_q <= '0;                               // Row 0 parity 0 read in SETUP
        end
        else if (state_q == SETUP)
        begin
            addr_q <= 4'd1;                             // Row 0 parity 1 for beat 1
        end
        else if (beat_take)
        begin
            beat_q <= beat_q + 6'd1;
            case (beat_q[2:0])
                3'd0:    addr_q <= addr_q - 4'd1;
                3'd1:    addr_q <= addr_q + 4'd1;
                3'd2:    addr_q <= addr_q;              // Same word again
                3'd3:    addr_q <= addr_q - 4'd1;
                3'd4:    addr_q <= addr_q + 4'd1;
                3'd5:    addr_q <= addr_q - 4'd1;
                3'd6:    addr_q <= addr_q + 4'd2;       // Next row parity 0
                default: addr_q <= addr_q + 4'd1;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    // Output never runs ahead of the tracker
    a_valid_on_full: assert property (
        @(posedge clk_i) disable iff (rst_i)
        v_o |-> slot_full_i
    );

endmodule

// ==== testbench/tb_jpeg_idct_ram.sv ====
`timescale 1ns/1ps

module tb_jpeg_idct_ram;

    import jpeg_idct_pkg::*;

    localparam int TOTAL_BLOCKS = 40;                   // Blocks written over the run
    localparam int MAX_CYCLES   = 50000;                // 40 blocks of up to ~600 cycles, plus margin
    localparam int STALL_AT     = 20;                   // Ring full test starts here
    localparam int FLUSH_AT     = 30;                   // Mid-block flush after this many
    localparam int STALL_HOLD   = 30;                   // Cycles of ready low before releasing

    logic      clk_i;
    logic      rst_i;
    logic      img_start_i;
    logic      inport_valid_i;
    coef_t     inport_data_i;
    coef_idx_t inport_idx_i;
    logic      inport_eob_i;
    logic      yumi_i;
    logic      ready_o;
    logic      v_o;
    coef_t     outport_data0_o;
    coef_t     outport_data1_o;
    coef_t     outport_data2_o;
    coef_t     outport_data3_o;
    lane_idx_t outport_idx_o;

    jpeg_idct_ram dut0 (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .img_start_i     (img_start_i),
        .inport_valid_i  (inport_valid_i),
        .inport_data_i   (inport_data_i),
        .inport_idx_i    (inport_idx_i),
        .inport_eob_i    (inport_eob_i),
        .yumi_i          (yumi_i),
        .ready_o         (ready_o),
        .v_o             (v_o),
        .outport_data0_o (outport_data0_o),
        .outport_data1_o (outport_data1_o),
        .outport_data2_o (outport_data2_o),
        .outport_data3_o (outport_data3_o),
        .outport_idx_o   (outport_idx_o)
    );

    // ----------------------------------------------------------------------
    // Clock, LFSR and model state
    // ----------------------------------------------------------------------
    logic [15:0] lfsr_q;                                // Galois LFSR state
    int          cycle_cnt;
    int          errors;
    coef_t       m_val  [NUM_BLOCKS][BLOCK_COEFS];      // Model coefficient values
    logic        m_wrt  [NUM_BLOCKS][BLOCK_COEFS];      // Model written flags
    logic        m_full [NUM_BLOCKS];
    int          m_wr_ptr;
    int          m_rd_ptr;
    int          m_beat;                                // Beat of the block on the outputs
    coef_idx_t   blk_q[$];                              // Index order of the block being sent
    int          pos;

    initial
    begin
        clk_i = 1'b0;
        forever
        begin
            #50 clk_i = ~clk_i;                         // 100 ns period
        end
    end

    // One step per bit taken, bit 0 shifts out first
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            b      = lfsr_q[0];
            lfsr_q = (lfsr_q >> 1) ^ (b ? 16'hB400 : 16'h0000);
            r      = (r << 1) | 16'(b);
        end
        return r;
    endfunction

    // Column parity per beat within a row
    function automatic int lane_parity(input int k);
        case (k % 8)
            1, 3, 4, 6: return 1;
            default:    return 0;
        endcase
    endfunction

    function automatic coef_t expected_coef(input int slot, input int idx);
        return m_wrt[slot][idx] ? m_val[slot][idx] : coef_t'(0);
    endfunction

    // Slots holding a whole block in the model
    function automatic int count_full_slots();
        int n;
        n = 0;
        for (int s = 0; s < NUM_BLOCKS; s++)
        begin
            if (m_full[s])
            begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic build_block();
        coef_idx_t t;
        int        j;
        blk_q.delete();
        for (int i = 0; i < BLOCK_COEFS; i++)
        begin
            if (take_bits(1))
            begin
                blk_q.push_back(coef_idx_t'(i));        // Keep each index with 1/2 chance
            end
        end
        if (blk_q.size() == 0)
        begin
            blk_q.push_back(coef_idx_t'(take_bits(6))); // EOB needs a beat to ride on
        end
        for (int i = blk_q.size() - 1; i > 0; i--)
        begin
            j        = int'(take_bits(6)) % (i + 1);    // Shuffle write order
            t        = blk_q[i];
            blk_q[i] = blk_q[j];
            blk_q[j] = t;
        end
        pos = 0;
    endtask

    task automatic report_mismatch(input string name, input int got, input int exp);
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic clear_model();
        for (int s = 0; s < NUM_BLOCKS; s++)
        begin
            m_full[s] = 1'b0;
            for (int i = 0; i < BLOCK_COEFS; i++)
            begin
                m_wrt[s][i] = 1'b0;
            end
        end
        m_wr_ptr = 0;
        m_rd_ptr = 0;
        m_beat   = 0;
    endtask

    always @(posedge clk_i)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Closing: %0d errors", errors);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus and checks
    // ----------------------------------------------------------------------
    initial
    begin
        coef_t lanes [4];
        coef_t held  [4];
        int    blocks_written;
        int    blocks_read;
        int    full_cycles;
        int    exp_idx;
        logic  exp_ready;
        logic  stall;
        logic  stall_done;
        logic  flush_req;
        logic  flush_done;
        logic  after_flush;
        logic  hold_chk;
        int    held_idx;
        logic  acc;
        logic  cons;

        lfsr_q         = 16'd1734;
        cycle_cnt      = 0;
        errors         = 0;
        blocks_written = 0;
        blocks_read    = 0;
        full_cycles    = 0;
        exp_ready      = 1'b1;
        stall          = 1'b0;
        stall_done     = 1'b0;
        flush_req      = 1'b0;
        flush_done     = 1'b0;
        after_flush    = 1'b0;
        hold_chk       = 1'b0;
        held_idx       = 0;
        rst_i          = 1'b1;
        img_start_i    = 1'b0;
        inport_valid_i = 1'b0;
        inport_data_i  = '0;
        inport_idx_i   = '0;
        inport_eob_i   = 1'b0;
        yumi_i         = 1'b0;
        clear_model();
        blk_q.delete();
        pos = 0;

        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;

        forever
        begin
            @(posedge clk_i);
            // Drive the next cycle
            img_start_i <= flush_req;
            if (flush_req)
            begin
                inport_valid_i <= 1'b0;                 // No write in the flush cycle
                pos            = blk_q.size();          // Abandon partial block
            end
            else
            begin
                if (blocks_written < TOTAL_BLOCKS && pos >= blk_q.size())
                begin
                    build_block();
                end
                if (pos < blk_q.size())
                begin
                    inport_valid_i <= (take_bits(2) != '0);    // 3/4 chance
                    inport_idx_i   <= blk_q[pos];
                    inport_eob_i   <= (pos == blk_q.size() - 1);
                    inport_data_i  <= coef_t'(take_bits(16));
                end
                else
                begin
                    inport_valid_i <= 1'b0;
                end
            end
            yumi_i    <= stall ? 1'b0 : (take_bits(1) != '0);
            flush_req = 1'b0;

            @(negedge clk_i);
            lanes[0] = outport_data0_o;
            lanes[1] = outport_data1_o;
            lanes[2] = outport_data2_o;
            lanes[3] = outport_data3_o;

            if (after_flush && v_o)
            begin
                $display("Error at %0t: v_o still high after the flush", $time);
                errors++;
            end
            after_flush = 1'b0;

            // Ready drops only when all four slots hold a block
            exp_ready = (count_full_slots() < NUM_BLOCKS);
            if (ready_o != exp_ready)
            begin
                report_mismatch("ready_o", int'(ready_o), int'(exp_ready));
            end

            if (img_start_i)
            begin
                clear_model();
                flush_done  = 1'b1;
                after_flush = 1'b1;
                hold_chk    = 1'b0;
                continue;
            end

            if (hold_chk)
            begin
                if (!v_o)
                begin
                    $display("Error at %0t: v_o dropped while stalled", $time);
                    errors++;
                end
                if (outport_idx_o != lane_idx_t'(held_idx))
                begin
                    report_mismatch("outport_idx_o held", int'(outport_idx_o), held_idx);
                end
                for (int b = 0; b < 4; b++)
                begin
                    if (lanes[b] != held[b])
                    begin
                        report_mismatch($sformatf("outport_data%0d_o held", b),
                                        int'(lanes[b]), int'(held[b]));
                    end
                end
            end

            if (v_o)
            begin
                if (!m_full[m_rd_ptr])
                begin
                    $display("Error at %0t: v_o high with no full block in the model", $time);
                    errors++;
                end
                if (outport_idx_o != lane_idx_t'(m_beat % 8))
                begin
                    report_mismatch("outport_idx_o", int'(outport_idx_o), m_beat % 8);
                end
                for (int b = 0; b < 4; b++)
                begin
                    exp_idx = (m_beat / 8) * 8 + 2 * b + lane_parity(m_beat);
                    if (lanes[b] != expected_coef(m_rd_ptr, exp_idx))
                    begin
                        report_mismatch($sformatf("outport_data%0d_o", b), int'(lanes[b]),
                                        int'(expected_coef(m_rd_ptr, exp_idx)));
                    end
                end
            end

            hold_chk = v_o && !yumi_i;                  // Outputs must hold next cycle
            held_idx = int'(outport_idx_o);
            held     = lanes;

            acc  = inport_valid_i && exp_ready;
            cons = v_o && yumi_i;
            if (acc)
            begin
                m_val[m_wr_ptr][inport_idx_i] = inport_data_i;
                m_wrt[m_wr_ptr][inport_idx_i] = 1'b1;
                pos++;
                if (inport_eob_i)
                begin
                    m_full[m_wr_ptr] = 1'b1;
                    m_wr_ptr         = (m_wr_ptr + 1) % NUM_BLOCKS;
                    blocks_written++;
                end
            end
            if (cons)
            begin
                if (m_beat == LAST_BEAT)
                begin
                    for (int i = 0; i < BLOCK_COEFS; i++)
                    begin
                        m_wrt[m_rd_ptr][i] = 1'b0;      // Slot freed
                    end
                    m_full[m_rd_ptr] = 1'b0;
                    m_rd_ptr         = (m_rd_ptr + 1) % NUM_BLOCKS;
                    m_beat           = 0;
                    blocks_read++;
                end
                else
                begin
                    m_beat++;
                end
            end

            // Ring full phase with the consumer stopped
            if (blocks_written >= STALL_AT && !stall_done)
            begin
                stall = 1'b1;
                if (!ready_o)
                begin
                    full_cycles++;
                end
                if (full_cycles >= STALL_HOLD)
                begin
                    stall      = 1'b0;
                    stall_done = 1'b1;
                end
            end

            if (blocks_written >= FLUSH_AT && !flush_done && v_o && m_beat == 20)
            begin
                flush_req = 1'b1;
            end

            if (blocks_written >= TOTAL_BLOCKS && !v_o && pos >= blk_q.size() &&
                !m_full[0] && !m_full[1] && !m_full[2] && !m_full[3])
            begin
                break;
            end
        end

        if (!stall_done)
        begin
            $display("Error: ring never reported full");
            errors++;
        end
        if (!flush_done)
        begin
            $display("Error: flush was never applied");
            errors++;
        end
        $display("Closing: %0d errors, %0d blocks written, %0d blocks read",
                 errors, blocks_written, blocks_read);
        if (errors == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
